// ==== mvu_core.f ====
mvu_cfg_pkg.sv
mvu_types_pkg.sv
plane_if.sv
plane_agu.sv
mvu_job_ctrl.sv
plane_mac.sv
mvu_core.sv
+incdir+.
tb_mvu_core.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the MVU testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_mvu_core \
    -f mvu_core.f -o tb_mvu_core \
    && sim_out="$(./obj_dir/tb_mvu_core)" \
    && echo "$sim_out" \
    && grep -q "TESTBENCH PASSED" <<< "$sim_out" \
    && echo "Simulation run succeeded" \
    || { echo "Simulation run did not pass"; exit 1; }

// ==== tb_mvu_model.svh ====
`ifndef TB_MVU_MODEL_SVH
`define TB_MVU_MODEL_SVH

// Bit-plane memories with plane b of an operand at base + b
weight_word_t wmem [1<<BWADDR];
data_word_t   dmem [1<<BDADDR];

// Addresses seen while rd_en was high in issue order
weight_addr_t seen_w [$];
data_addr_t   seen_i [$];

// Two's complement value of a prec-bit operand
function automatic int operand_value(input int bits, input int prec, input logic sgn);
    if (sgn && bits[prec-1]) begin
        return bits - (1 << prec);
    end
    return bits;
endfunction

task automatic load_planes(input int wp, input int ip, input int wb, input int ib);
    for (int b = 0; b < wp; b++) begin
        wmem[weight_addr_t'(wb + b)] = {$random(seed), $random(seed)};
    end
    for (int b = 0; b < ip; b++) begin
        dmem[data_addr_t'(ib + b)] = data_word_t'($random(seed));
    end
endtask

task automatic clear_trace();
    seen_w.delete();
    seen_i.delete();
endtask

// Row r of W times x rebuilt from the planes as whole integers
function automatic int expected_row(input int r, input int wp, input int ip, input logic ws,
                                    input logic ds, input int wb, input int ib);
    int           sum;
    int           wv;
    int           xv;
    weight_word_t wplane;
    data_word_t   dplane;
    sum = 0;
    for (int c = 0; c < N; c++) begin
        wv = 0;
        xv = 0;
        for (int b = 0; b < wp; b++) begin
            wplane = wmem[weight_addr_t'(wb + b)];
            wv = wv | (int'(wplane[r*N+c]) << b);       // Column c of row r
        end
        for (int b = 0; b < ip; b++) begin
            dplane = dmem[data_addr_t'(ib + b)];
            xv = xv | (int'(dplane[c]) << b);
        end
        sum = sum + operand_value(wv, wp, ws) * operand_value(xv, ip, ds);
    end
    return sum;
endfunction

// Memory responder with a read latency of one cycle
initial begin : responder
    logic         rd_seen;
    weight_addr_t wa;
    data_addr_t   ia;
    w_word = '0;
    i_word = '0;
    forever begin
        @(negedge clk);                                 // Addresses are stable mid-cycle
        rd_seen = rd_en;
        wa      = w_addr;
        ia      = i_addr;
        if (rd_en) begin
            seen_w.push_back(w_addr);
            seen_i.push_back(i_addr);
        end
        @(posedge clk);
        #1;
        if (rd_seen) begin
            w_word = wmem[wa];
            i_word = dmem[ia];
        end else begin
            w_word = '1;                                // Junk the MAC must ignore
            i_word = '1;
        end
    end
end

`endif

// ==== tb_mvu_core.sv ====
`timescale 1ns/10ps

module tb_mvu_core
    import mvu_cfg_pkg::*, mvu_types_pkg::*;
();

    localparam int SEED       = 32'h287a2f4a;
    localparam int NUM_JOBS   = 30;                         // Unsigned random jobs
    localparam int DONE_LIMIT = MAX_PREC * MAX_PREC + 8;   // Cycles allowed from start to done

    logic              clk;
    logic              rst_n;
    logic              start;
    prec_t             w_prec;
    prec_t             i_prec;
    logic              w_signed;
    logic              d_signed;
    weight_addr_t      w_base;
    data_addr_t        i_base;
    logic              rd_en;
    weight_addr_t      w_addr;
    data_addr_t        i_addr;
    weight_word_t      w_word;
    data_word_t        i_word;
    logic              done;
    logic              irq;
    logic              busy;
    logic [N*BACC-1:0] result;

    integer seed;
    int     errors;
    int     checks;
    bit     timed_out;

    `include "tb_mvu_model.svh"

    mvu_core mvu_core_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .w_prec   (w_prec),
        .i_prec   (i_prec),
        .w_signed (w_signed),
        .d_signed (d_signed),
        .w_base   (w_base),
        .i_base   (i_base),
        .rd_en    (rd_en),
        .w_addr   (w_addr),
        .i_addr   (i_addr),
        .w_word   (w_word),
        .i_word   (i_word),
        .done     (done),
        .irq      (irq),
        .busy     (busy),
        .result   (result)
    );

    always #50 clk = ~clk;

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    task automatic check_value(input string name, input int expected, input int actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("** Error at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
        end
    endtask

    // One job from start to done with an optional extra start while busy
    task automatic run_job(input int wp, input int ip, input logic ws, input logic ds,
                           input int wb, input int ib, input bit poke);
        int p;
        int cycles;
        int act;
        int n_addr;
        p = wp * ip;
        load_planes(wp, ip, wb, ib);
        clear_trace();
        w_prec   = prec_t'(wp);
        i_prec   = prec_t'(ip);
        w_signed = ws;
        d_signed = ds;
        w_base   = weight_addr_t'(wb);
        i_base   = data_addr_t'(ib);
        start    = 1'b1;
        @(posedge clk);                                 // Edge 0 accepts the job
        #1;
        start = 1'b0;
        check_value("irq", 0, irq);
        check_value("busy", 1, busy);
        cycles = 0;
        while (!done && cycles < DONE_LIMIT) begin
            @(posedge clk);
            #1;
            cycles++;
            start = poke && (cycles == 1);
            if (start) begin
                w_prec   = prec_t'(rand_range(1, MAX_PREC));     // A different job, must be dropped
                i_prec   = prec_t'(rand_range(1, MAX_PREC));
                w_signed = ~ws;
                d_signed = ~ds;
                w_base   = weight_addr_t'($random(seed));
                i_base   = data_addr_t'($random(seed));
            end
        end
        if (!done) begin
            errors++;
            timed_out = 1'b1;
            $display("Timeout: done did not rise within %0d cycles of start", DONE_LIMIT);
        end else begin
            check_value("done latency", p + 2, cycles);
            check_value("busy", 0, busy);
            check_value("rd_en cycles", p, seen_w.size());
            n_addr = (seen_w.size() < p) ? seen_w.size() : p;
            for (int k = 0; k < n_addr; k++) begin
                // Input planes walk outside the weight planes and both go MSB first
                check_value("w_addr", weight_addr_t'(wb + wp - 1 - k % wp), seen_w[k]);
                check_value("i_addr", data_addr_t'(ib + ip - 1 - k / wp), seen_i[k]);
            end
            for (int r = 0; r < N; r++) begin
                act = $signed(result[r*BACC +: BACC]);
                check_value($sformatf("result[%0d]", r),
                            expected_row(r, wp, ip, ws, ds, wb, ib), act);
            end
            @(posedge clk);
            #1;
            check_value("done", 0, done);               // Pulse lasts one cycle
            check_value("irq", 1, irq);
            repeat (rand_range(0, 2)) begin
                @(posedge clk);
                #1;
                check_value("irq", 1, irq);
            end
        end
    endtask

    initial begin
        int wp;
        int ip;
        seed      = SEED;
        errors    = 0;
        checks    = 0;
        timed_out = 1'b0;
        clk       = 1'b0;
        rst_n     = 1'b0;
        start     = 1'b0;
        w_prec    = prec_t'(1);
        i_prec    = prec_t'(1);
        w_signed  = 1'b0;
        d_signed  = 1'b0;
        w_base    = '0;
        i_base    = '0;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // State straight out of reset
        check_value("done", 0, done);
        check_value("irq", 0, irq);
        check_value("busy", 0, busy);
        check_value("rd_en", 0, rd_en);
        for (int r = 0; r < N; r++) begin
            check_value($sformatf("result[%0d]", r), 0, $signed(result[r*BACC +: BACC]));
        end

        for (int j = 0; j < NUM_JOBS && !timed_out; j++) begin
            run_job(rand_range(1, MAX_PREC), rand_range(1, MAX_PREC), 1'b0, 1'b0,
                    rand_range(0, (1 << BWADDR) - 1), rand_range(0, (1 << BDADDR) - 1),
                    j % 3 == 1);
        end

        // Every signedness pair with the extreme precisions
        for (int s = 0; s < 4 && !timed_out; s++) begin
            for (int j = 0; j < 4 && !timed_out; j++) begin
                case (j)
                    0: begin
                        wp = MAX_PREC;
                        ip = MAX_PREC;
                    end
                    1: begin
                        wp = 1;
                        ip = MAX_PREC;
                    end
                    2: begin
                        wp = MAX_PREC;
                        ip = 1;
                    end
                    default: begin
                        wp = rand_range(1, MAX_PREC);
                        ip = rand_range(1, MAX_PREC);
                    end
                endcase
                run_job(wp, ip, s[1], s[0], rand_range(0, (1 << BWADDR) - 1),
                        rand_range(0, (1 << BDADDR) - 1), j == 3);
            end
        end

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== mvu_core.sv ====
`timescale 1ns/10ps

module mvu_core
    import mvu_cfg_pkg::*, mvu_types_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    input  prec_t             w_prec,
    input  prec_t             i_prec,
    input  logic              w_signed,
    input  logic              d_signed,
    input  weight_addr_t      w_base,
    input  data_addr_t        i_base,
    output logic              rd_en,        // Read strobe for both memories
    output weight_addr_t      w_addr,
    output data_addr_t        i_addr,
    input  weight_word_t      w_word,       // Returned one cycle after rd_en
    input  data_word_t        i_word,
    output logic              done,
    output logic              irq,
    output logic              busy,
    output logic [N*BACC-1:0] result        // Row r in slice r
);

    job_cfg_t job_in;
    job_cfg_t cfg;
    logic     load;
    logic     run;
    logic     w_wrap;
    logic     in_wrap;
    acc_t     row_acc [N];

    plane_if #(.addr_t(weight_addr_t)) w_plane ();
    plane_if #(.addr_t(data_addr_t))   d_plane ();

    assign job_in = '{w_prec: w_prec, i_prec: i_prec, w_signed: w_signed,
                      d_signed: d_signed, w_base: w_base, i_base: i_base};

    mvu_job_ctrl ctrl_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (start),
        .job_in  (job_in),
        .in_wrap (in_wrap),
        .cfg     (cfg),
        .load    (load),
        .run     (run),
        .busy    (busy),
        .done    (done),
        .irq     (irq)
    );

    // Inner loop, steps every running cycle
    plane_agu #(.addr_t(weight_addr_t)) w_agu_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .load    (load),
        .base    (cfg.w_base),
        .prec    (cfg.w_prec),
        .advance (run),
        .wrap    (w_wrap),
        .plane   (w_plane)
    );

    // Outer loop, steps when the weight walk wraps
    plane_agu #(.addr_t(data_addr_t)) d_agu_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .load    (load),
        .base    (cfg.i_base),
        .prec    (cfg.i_prec),
        .advance (w_wrap),
        .wrap    (in_wrap),
        .plane   (d_plane)
    );

    plane_mac mac_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .clear    (load),
        .run      (run),
        .w_signed (cfg.w_signed),
        .d_signed (cfg.d_signed),
        .w_plane  (w_plane),
        .d_plane  (d_plane),
        .w_word   (w_word),
        .i_word   (i_word),
        .result   (row_acc)
    );

    assign rd_en  = run;
    assign w_addr = w_plane.addr;
    assign i_addr = d_plane.addr;

    for (genvar r = 0; r < N; r++) begin : g_result
        assign result[r*BACC +: BACC] = row_acc[r];
    end

endmodule

// ==== plane_mac.sv ====
`timescale 1ns/10ps

module plane_mac
    import mvu_cfg_pkg::*, mvu_types_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         clear,         // Zero all rows at the start of a job
    input  logic         run,
    input  logic         w_signed,
    input  logic         d_signed,
    plane_if.sink        w_plane,
    plane_if.sink        d_plane,
    input  weight_word_t w_word,        // Arrives MEM_RD_LATENCY cycles after its address
    input  data_word_t   i_word,
    output acc_t         result [N]
);

    logic                      neg;
    logic [MEM_RD_LATENCY-1:0] run_sr;
    logic [MEM_RD_LATENCY-1:0] neg_sr;
    bit_idx_t                  w_idx_sr [MEM_RD_LATENCY];
    bit_idx_t                  d_idx_sr [MEM_RD_LATENCY];
    logic                      acc_en;
    logic                      acc_neg;
    logic [BIDX:0]             shamt;       // Weight bit plus input bit, up to 14
    acc_t                      term [N];

    function automatic acc_t popcount(input data_word_t v);
        acc_t cnt;
        cnt = '0;
        for (int c = 0; c < N; c++) begin
            cnt = cnt + acc_t'(v[c]);
        end
        return cnt;
    endfunction

    // Sign planes carry negative weight in two's complement
    assign neg = (w_signed & w_plane.msb) ^ (d_signed & d_plane.msb);

    // Plane information follows the words through the memory latency
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            run_sr <= '0;
        end else begin
            run_sr[0] <= run;
            for (int k = 1; k < MEM_RD_LATENCY; k++) begin
                run_sr[k] <= run_sr[k-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        neg_sr[0]   <= neg;
        w_idx_sr[0] <= w_plane.bit_idx;
        d_idx_sr[0] <= d_plane.bit_idx;
        for (int k = 1; k < MEM_RD_LATENCY; k++) begin
            neg_sr[k]   <= neg_sr[k-1];
            w_idx_sr[k] <= w_idx_sr[k-1];
            d_idx_sr[k] <= d_idx_sr[k-1];
        end
    end

    assign acc_en  = run_sr[MEM_RD_LATENCY-1];
    assign acc_neg = neg_sr[MEM_RD_LATENCY-1];
    assign shamt   = {1'b0, w_idx_sr[MEM_RD_LATENCY-1]} + {1'b0, d_idx_sr[MEM_RD_LATENCY-1]};

    always_comb begin
        for (int r = 0; r < N; r++) begin
            term[r] = popcount(w_word[r*N +: N] & i_word) <<< shamt;    // Row r times one plane pair
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || clear) begin
            for (int r = 0; r < N; r++) begin
                result[r] <= '0;
            end
        end else if (acc_en) begin
            for (int r = 0; r < N; r++) begin
                if (acc_neg) begin
                    result[r] <= result[r] - term[r];
                end else begin
                    result[r] <= result[r] + term[r];
                end
            end
        end
    end

endmodule

// ==== mvu_job_ctrl.sv ====
`timescale 1ns/10ps

module mvu_job_ctrl
    import mvu_cfg_pkg::*, mvu_types_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     start,         // One-cycle strobe
    input  job_cfg_t job_in,
    input  logic     in_wrap,       // Outer walk finished its last plane
    output job_cfg_t cfg,
    output logic     load,          // Job accepted this cycle
    output logic     run,
    output logic     busy,
    output logic     done,          // One-cycle pulse
    output logic     irq            // Held until the next accepted start
);

    job_cfg_t                cfg_q;
    logic                    job_end;
    logic [MEM_RD_LATENCY:0] drain_sr;      // Last reads still in flight through the MAC

    assign load    = start & ~busy;
    assign job_end = run & in_wrap;

    // The generators load on the accepting edge and need the new job already
    assign cfg = load ? job_in : cfg_q;

    always_ff @(posedge clk) begin
        if (load) begin
            cfg_q <= job_in;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            run      <= 1'b0;
            busy     <= 1'b0;
            done     <= 1'b0;
            irq      <= 1'b0;
            drain_sr <= '0;
        end else begin
            drain_sr[0] <= job_end;
            for (int k = 1; k <= MEM_RD_LATENCY; k++) begin
                drain_sr[k] <= drain_sr[k-1];
            end
            done <= drain_sr[MEM_RD_LATENCY];

            if (load) begin
                run  <= 1'b1;
                busy <= 1'b1;
                irq  <= 1'b0;               // A new job acknowledges the old interrupt
            end else begin
                if (job_end) begin
                    run <= 1'b0;
                end
                if (drain_sr[MEM_RD_LATENCY]) begin
                    busy <= 1'b0;           // Falls together with done
                    irq  <= 1'b1;
                end
            end
        end
    end

    // The generators keep seeing the running job when a late start arrives
    a_start_ignored_busy: assert property (
        @(posedge clk) disable iff (!rst_n)
        (start && busy) |-> $stable(cfg)
    ) else $error("start while busy changed the job seen by the generators");

    a_prec_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        load |-> (job_in.w_prec inside {[1:MAX_PREC]}) &&
                 (job_in.i_prec inside {[1:MAX_PREC]})
    ) else $error("job accepted with a precision outside 1 to %0d", MAX_PREC);

endmodule

// ==== plane_agu.sv ====
`timescale 1ns/10ps

module plane_agu
    import mvu_cfg_pkg::*, mvu_types_pkg::*;
#(
    parameter type addr_t = data_addr_t
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  load,             // New job, start at the MSB plane
    input  addr_t base,
    input  prec_t prec,
    input  logic  advance,          // Step to the next lower plane
    output logic  wrap,             // Stepped past plane 0
    plane_if.src  plane
);

    bit_idx_t bit_q;
    bit_idx_t top_idx;

    assign top_idx = bit_idx_t'(prec - prec_t'(1));     // Precision 1..8 maps onto 0..7

    // Bit-plane counter runs MSB first down to plane 0
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bit_q <= '0;
        end else if (load || wrap) begin
            bit_q <= top_idx;                           // Restart so the outer loop sees a fresh walk
        end else if (advance) begin
            bit_q <= bit_q - BIDX'(1);
        end
    end

    assign plane.bit_idx = bit_q;
    assign plane.msb     = (bit_q == top_idx);
    assign plane.last    = (bit_q == '0);
    assign plane.addr    = base + addr_t'(bit_q);      // Plane b sits at base + b

    assign wrap = advance & plane.last;

    // The controller only raises run after the load edge
    a_no_advance_on_load: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(advance && load)
    ) else $error("plane_agu advanced while loading a job");

endmodule

// ==== plane_if.sv ====
`timescale 1ns/10ps

interface plane_if
    import mvu_types_pkg::*;
#(
    parameter type addr_t = data_addr_t
);

    addr_t    addr;                 // Plane address for the memory
    bit_idx_t bit_idx;              // Bit of the operand held in this plane
    logic     msb;                  // On the sign plane of the operand
    logic     last;                 // On plane 0, the walk ends here

    // Driven by an address generator
    modport src (
        output addr, bit_idx, msb, last
    );

    // Valid whenever run is high
    modport sink (
        input addr, bit_idx, msb, last
    );

endinterface

// ==== mvu_types_pkg.sv ====
package mvu_types_pkg;

    import mvu_cfg_pkg::*;

    typedef logic [BPREC-1:0]  prec_t;          // Operand precision, 1 to MAX_PREC
    typedef logic [BIDX-1:0]   bit_idx_t;       // Bit-plane index within an operand

    typedef logic [BWADDR-1:0] weight_addr_t;
    typedef logic [BDADDR-1:0] data_addr_t;

    // Row r of the weight plane is slice r, bit c of that slice is column c
    typedef logic [N*N-1:0]    weight_word_t;
    typedef logic [N-1:0]      data_word_t;     // Bit c is element c of the input plane

    typedef logic signed [BACC-1:0] acc_t;

    // One job as latched on start
    typedef struct packed {
        prec_t        w_prec;
        prec_t        i_prec;
        logic         w_signed;
        logic         d_signed;
        weight_addr_t w_base;                   // Address of weight plane 0
        data_addr_t   i_base;                   // Address of input plane 0
    } job_cfg_t;

endpackage

// ==== mvu_cfg_pkg.sv ====
package mvu_cfg_pkg;

    // Array geometry
    localparam int N = 8;                    // Vector length and matrix side

    // Precision of the bit-serial operands
    localparam int BPREC    = 4;             // Width of a precision field
    localparam int MAX_PREC = 8;             // Widest operand in bits
    localparam int BIDX     = 3;             // Width of a bit-plane index

    // Memory address widths
    localparam int BWADDR = 9;               // Weight memory address
    localparam int BDADDR = 15;              // Data memory address

    // Accumulator
    // Worst case is 8 columns of 255 x 255, plus a sign bit
    localparam int BACC = 21;

    // External memory timing
    localparam int MEM_RD_LATENCY = 1;       // Cycles from address to returned word

endpackage
